/* tb.f */
logic/pdp8_pkg.sv
logic/major_cycle_if.sv
logic/core_ram.sv
logic/mem_addr_unit.sv
logic/major_state_seq.sv
logic/pdp8_mem_top.sv
dv/clk_gen.sv
dv/pdp8_mem_asserts.sv
dv/pdp8_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pdp8_mem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/pdp8_mem_tb.sv */
`timescale 1ns/1ps

module pdp8_mem_tb;
    import pdp8_pkg::*;

    typedef enum logic [2:0] {LOAD_ADDR, DEPOSIT, EXAMINE, RUN_PROG, WAIT_HALT} step_kind_t;

    typedef struct packed {
        step_kind_t kind;
        word_t      sr;
        field_t     fld;
        logic       irq;
        logic       chk_ma;
        word_t      exp_ma;
        logic       chk_md;
        word_t      exp_md;
    } step_t;

    logic   clk;
    logic   reset;
    logic   run;
    logic   int_request;
    logic   addr_load;
    logic   dep;
    logic   exam;
    word_t  ac;
    word_t  sr;
    field_t if_field;
    field_t df_field;
    word_t  pc;
    word_t  ma;
    word_t  mdout;
    word_t  instruction;
    field_t ema;
    logic   running;

    step_t  steps[$];
    word_t  rnd_words[8];
    word_t  next_addr;      // panel address while the table is built
    field_t cur_fld;
    int     seed = 64500;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit = 0;

    clk_gen clk_gen_i (.clk(clk), .reset(reset));

    pdp8_mem_top pdp8_mem_top_i (
        .clk(clk), .reset(reset), .run(run), .int_request(int_request),
        .addr_load(addr_load), .dep(dep), .exam(exam), .ac(ac), .sr(sr),
        .if_field(if_field), .df_field(df_field), .pc(pc), .ma(ma), .mdout(mdout),
        .instruction(instruction), .ema(ema), .running(running)
    );

    task automatic add_step(input step_kind_t kind, input word_t val, input logic irq,
                            input logic chk_ma, input word_t exp_ma,
                            input logic chk_md, input word_t exp_md);
        step_t s;
        s.kind   = kind;
        s.sr     = val;
        s.fld    = cur_fld;
        s.irq    = irq;
        s.chk_ma = chk_ma;
        s.exp_ma = exp_ma;
        s.chk_md = chk_md;
        s.exp_md = exp_md;
        steps.push_back(s);
    endtask

    task automatic load_at(input word_t a, input field_t f);
        cur_fld   = f;
        next_addr = a;
        add_step(LOAD_ADDR, a, 1'b0, 1'b1, a, 1'b0, 12'o0);
    endtask

    task automatic deposit_word(input word_t w);
        add_step(DEPOSIT, w, 1'b0, 1'b1, next_addr + 12'o1, 1'b0, 12'o0);
        next_addr = next_addr + 12'o1;
    endtask

    task automatic examine_word(input word_t w);
        add_step(EXAMINE, 12'o0, 1'b0, 1'b1, next_addr + 12'o1, 1'b1, w);
        next_addr = next_addr + 12'o1;
    endtask

    task automatic start_run(input logic irq);
        cur_fld = 3'o0;
        add_step(RUN_PROG, 12'o0, irq, 1'b0, 12'o0, 1'b0, 12'o0);
    endtask

    task automatic wait_halt(input word_t halt_ma);
        add_step(WAIT_HALT, 12'o0, 1'b0, 1'b1, halt_ma, 1'b1, HLT_WORD);
    endtask

    task automatic check_step(input int idx, input step_t s);
        word_t exp_pc;
        checks++;
        if (s.chk_ma && ma !== s.exp_ma) begin
            $display("mismatch step %0d ma: got %h expected %h", idx, ma, s.exp_ma);
            errors++;
        end
        if (s.chk_md && mdout !== s.exp_md) begin
            $display("mismatch step %0d mdout: got %h expected %h", idx, mdout, s.exp_md);
            errors++;
        end
        if (ema !== s.fld) begin
            $display("mismatch step %0d ema: got %h expected %h", idx, ema, s.fld);
            errors++;
        end
        if (running !== 1'b0) begin
            $display("mismatch step %0d running: got %h expected %h", idx, running, 1'b0);
            errors++;
        end
        if (s.kind == WAIT_HALT) begin
            exp_pc = s.exp_ma + 12'o1;  // pc steps past the HLT in F3
            if (pc !== exp_pc) begin
                $display("mismatch step %0d pc: got %h expected %h", idx, pc, exp_pc);
                errors++;
            end
            if (instruction !== HLT_WORD) begin
                $display("mismatch step %0d instruction: got %h expected %h",
                         idx, instruction, HLT_WORD);
                errors++;
            end
        end
    endtask

    task automatic apply_step(input int idx, input step_t s);
        @(posedge clk);
        sr       <= s.sr;
        if_field <= s.fld;
        case (s.kind)
            RUN_PROG: begin
                run         <= 1'b1;
                int_request <= s.irq;
                @(negedge clk);
                while (!running) @(negedge clk);
            end
            WAIT_HALT: begin
                @(negedge clk);
                while (running) @(negedge clk);
                @(posedge clk);
                run         <= 1'b0;
                int_request <= 1'b0;
                @(negedge clk);
                check_step(idx, s);
            end
            default: begin
                addr_load <= (s.kind == LOAD_ADDR);
                dep       <= (s.kind == DEPOSIT);
                exam      <= (s.kind == EXAMINE);
                @(posedge clk);
                addr_load <= 1'b0;
                dep       <= 1'b0;
                exam      <= 1'b0;
                repeat (5) @(posedge clk);  // one H cycle
                @(negedge clk);
                check_step(idx, s);
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        run = 1'b0;
        int_request = 1'b0;
        addr_load = 1'b0;
        dep = 1'b0;
        exam = 1'b0;
        ac = 12'o5252;
        sr = 12'o0;
        if_field = 3'o0;
        df_field = 3'o1;    // data field differs from the instruction field

        // panel sweep
        for (int i = 0; i < 8; i++) rnd_words[i] = word_t'($random(seed));
        load_at(12'o0400, 3'o0);
        for (int i = 0; i < 8; i++) deposit_word(rnd_words[i]);
        load_at(12'o0400, 3'o0);
        for (int i = 0; i < 8; i++) examine_word(rnd_words[i]);

        // program image
        load_at(12'o0000, 3'o0);
        deposit_word(12'o7000);
        deposit_word(12'o7402);
        deposit_word(12'o5403);     // jmp i 0003
        deposit_word(12'o0200);
        load_at(12'o0010, 3'o0);
        deposit_word(12'o0300);     // auto-index pointer
        load_at(12'o0050, 3'o0);
        deposit_word(12'o0000);
        deposit_word(12'o1234);
        deposit_word(12'o1111);     // skip marker
        load_at(12'o0200, 3'o0);
        deposit_word(12'o3050);
        deposit_word(12'o2220);
        deposit_word(12'o5205);
        deposit_word(12'o3051);
        deposit_word(12'o7402);
        deposit_word(12'o7402);
        deposit_word(12'o2221);
        deposit_word(12'o3052);
        deposit_word(12'o7402);
        deposit_word(12'o3410);
        deposit_word(12'o7402);
        deposit_word(12'o4230);
        load_at(12'o0220, 3'o0);
        deposit_word(12'o0005);
        deposit_word(12'o7777);
        load_at(12'o0230, 3'o0);
        deposit_word(12'o0000);
        deposit_word(12'o3632);
        deposit_word(12'o0100);
        deposit_word(12'o7402);
        deposit_word(12'o7000);

        start_run(1'b0);
        wait_halt(12'o0001);
        start_run(1'b0);            // dca, isz, jmp
        wait_halt(12'o0205);
        load_at(12'o0050, 3'o0);
        examine_word(12'o5252);
        examine_word(12'o1234);
        load_at(12'o0220, 3'o0);
        examine_word(12'o0006);
        start_run(1'b0);            // isz skip
        wait_halt(12'o0210);
        load_at(12'o0221, 3'o0);
        examine_word(12'o0000);
        load_at(12'o0052, 3'o0);
        examine_word(12'o1111);
        start_run(1'b0);            // dca i through 0010
        wait_halt(12'o0212);
        load_at(12'o0010, 3'o0);
        examine_word(12'o0301);
        load_at(12'o0301, 3'o1);
        examine_word(12'o5252);
        start_run(1'b0);            // jms, then dca i into the data field
        wait_halt(12'o0233);
        load_at(12'o0230, 3'o0);
        examine_word(12'o0214);
        load_at(12'o0100, 3'o1);
        examine_word(12'o5252);
        start_run(1'b1);            // interrupt after the nop at 0234
        wait_halt(12'o0001);
        load_at(12'o0000, 3'o0);
        examine_word(12'o0235);

        limit = steps.size() * 15 * 8 + 500;

        @(negedge clk);
        while (reset) @(negedge clk);
        foreach (steps[i]) apply_step(i, steps[i]);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* dv/pdp8_mem_asserts.sv */
`timescale 1ns/1ps

module pdp8_mem_asserts (
    input logic                   clk,
    input logic                   reset,
    input pdp8_pkg::major_state_t state,
    input logic                   write_en,
    input logic                   isz_skip,
    input logic                   running
);
    import pdp8_pkg::*;

    we_single_cycle: assert property (@(posedge clk) disable iff (reset)
        write_en |=> !write_en)
        else $error("write_en held high for two clocks");

    // X0 is always followed by the read-wait phase
    x0_then_wait: assert property (@(posedge clk) disable iff (reset)
        (state inside {F0, D0, E0, H0}) |=> (int'(state) == int'($past(state)) + 1))
        else $error("phase after X0 is not XW");

    no_skip_in_fetch: assert property (@(posedge clk) disable iff (reset)
        (state inside {F0, FW, F1, F2, F3}) |-> !isz_skip)
        else $error("isz_skip high during fetch");

    idle_not_running: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> !running)
        else $error("running high in IDLE");

endmodule

// sees the sequencer state and running and the memory unit's write strobe and skip flag
bind pdp8_mem_top pdp8_mem_asserts mem_asserts_i (
    .clk      (clk),
    .reset    (reset),
    .state    (cyc_if.state),
    .write_en (ram_we),
    .isz_skip (cyc_if.isz_skip),
    .running  (running)
);

/* dv/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* logic/pdp8_mem_top.sv */
`timescale 1ns/1ps

module pdp8_mem_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  logic             int_request,
    input  logic             addr_load,
    input  logic             dep,
    input  logic             exam,
    input  pdp8_pkg::word_t  ac,
    input  pdp8_pkg::word_t  sr,
    input  pdp8_pkg::field_t if_field,
    input  pdp8_pkg::field_t df_field,
    output pdp8_pkg::word_t  pc,
    output pdp8_pkg::word_t  ma,
    output pdp8_pkg::word_t  mdout,
    output pdp8_pkg::word_t  instruction,
    output pdp8_pkg::field_t ema,
    output logic             running
);
    import pdp8_pkg::*;

    core_addr_t core_addr;
    word_t      ram_din;
    word_t      ram_dout;
    logic       ram_we;

    major_cycle_if cyc_if ();

    assign ma          = cyc_if.ma;
    assign instruction = cyc_if.instruction;

    major_state_seq major_state_seq_i (
        .clk         (clk),
        .reset       (reset),
        .cyc         (cyc_if.seq),
        .run         (run),
        .int_request (int_request),
        .addr_load   (addr_load),
        .dep         (dep),
        .exam        (exam),
        .pc          (pc),
        .running     (running)
    );

    mem_addr_unit mem_addr_unit_i (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc_if.mem),
        .ac        (ac),
        .sr        (sr),
        .pc        (pc),
        .if_field  (if_field),
        .df_field  (df_field),
        .addr_load (addr_load),
        .dep       (dep),
        .mdout     (mdout),
        .ema       (ema),
        .core_addr (core_addr),
        .ram_din   (ram_din),
        .ram_we    (ram_we),
        .ram_dout  (ram_dout)
    );

    core_ram core_ram_i (
        .clk      (clk),
        .addr     (core_addr),
        .din      (ram_din),
        .write_en (ram_we),
        .dout     (ram_dout)
    );

endmodule

/* logic/major_state_seq.sv */
`timescale 1ns/1ps

module major_state_seq (
    input  logic            clk,
    input  logic            reset,
    major_cycle_if.seq      cyc,
    input  logic            run,
    input  logic            int_request,
    input  logic            addr_load,
    input  logic            dep,
    input  logic            exam,
    output pdp8_pkg::word_t pc,
    output logic            running
);
    import pdp8_pkg::*;

    major_state_t state;
    major_state_t end_state;    // where an instruction goes when it ends
    logic         int_in_prog;
    logic         halted;
    logic [0:2]   opcode;
    logic         indirect;
    logic         is_halt;
    word_t        jmp_target;

    assign cyc.state       = state;
    assign cyc.int_in_prog = int_in_prog;

    assign opcode     = cyc.instruction[0:2];
    assign indirect   = cyc.instruction[3];
    assign is_halt    = (cyc.instruction == HLT_WORD);
    assign jmp_target = {cyc.instruction[4] ? pc[0:4] : 5'o00, cyc.instruction[5:11]};

    always_comb begin
        if (int_request) begin
            end_state = E0;
        end else if (run) begin
            end_state = F0;
        end else begin
            end_state = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            pc          <= 12'o0000;
            running     <= 1'b0;
            int_in_prog <= 1'b0;
            halted      <= 1'b0;
        end else begin
            if (!run) begin
                halted <= 1'b0;     // HLT holds off restart until run drops
            end
            case (state)
                IDLE: begin
                    if (addr_load || dep || exam) begin
                        state <= H0;
                    end else if (run && !halted) begin
                        state   <= F0;
                        running <= 1'b1;
                    end
                end
                F0: state <= FW;
                FW: state <= F1;
                F1: state <= F2;
                F2: state <= F3;
                F3: begin
                    case (opcode)
                        AND, TAD, ISZ, DCA, JMS, JMP: begin
                            if (indirect) begin
                                pc    <= pc + 12'o0001;
                                state <= D0;
                            end else if (opcode == JMP) begin
                                pc          <= jmp_target;
                                state       <= end_state;
                                int_in_prog <= int_request;
                                running     <= (end_state != IDLE);
                            end else begin
                                pc    <= pc + 12'o0001;
                                state <= E0;
                            end
                        end
                        IOT, OPR: begin
                            pc <= pc + 12'o0001;
                            if (opcode == OPR && is_halt) begin
                                state   <= IDLE;
                                running <= 1'b0;
                                halted  <= 1'b1;
                            end else begin
                                state       <= end_state;
                                int_in_prog <= int_request;
                                running     <= (end_state != IDLE);
                            end
                        end
                    endcase
                end
                D0: state <= DW;
                DW: state <= D1;
                D1: state <= D2;
                D2: state <= D3;
                D3: begin
                    if (opcode == JMP) begin
                        pc          <= cyc.ma;
                        state       <= end_state;
                        int_in_prog <= int_request;
                        running     <= (end_state != IDLE);
                    end else begin
                        state <= E0;
                    end
                end
                E0: state <= EW;
                EW: state <= E1;
                E1: state <= E2;
                E2: state <= E3;
                E3: begin
                    if (opcode == JMS) begin
                        pc <= cyc.ma + 12'o0001;    // also the 0001 entry of an interrupt
                    end else if (opcode == ISZ && cyc.isz_skip) begin
                        pc <= pc + 12'o0001;
                    end
                    if (int_in_prog) begin
                        // no nested entry straight after the vector store
                        int_in_prog <= 1'b0;
                        state       <= run ? F0 : IDLE;
                        running     <= run;
                    end else begin
                        state       <= end_state;
                        int_in_prog <= int_request;
                        running     <= (end_state != IDLE);
                    end
                end
                H0: state <= HW;
                HW: state <= H1;
                H1: state <= H2;
                H2: state <= H3;
                H3: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/mem_addr_unit.sv */
`timescale 1ns/1ps

module mem_addr_unit (
    input  logic                 clk,
    input  logic                 reset,
    major_cycle_if.mem           cyc,
    input  pdp8_pkg::word_t      ac,
    input  pdp8_pkg::word_t      sr,
    input  pdp8_pkg::word_t      pc,
    input  pdp8_pkg::field_t     if_field,
    input  pdp8_pkg::field_t     df_field,
    input  logic                 addr_load,
    input  logic                 dep,
    output pdp8_pkg::word_t      mdout,
    output pdp8_pkg::field_t     ema,
    output pdp8_pkg::core_addr_t core_addr,
    output pdp8_pkg::word_t      ram_din,
    output logic                 ram_we,
    input  pdp8_pkg::word_t      ram_dout
);
    import pdp8_pkg::*;

    word_t      instruction;
    word_t      ma;
    word_t      mdin;
    word_t      addr;
    page_t      current_page;
    logic       isz_skip;
    logic       write_en;
    logic       load_q;         // panel strobes held for the H cycle
    logic       dep_q;
    logic [0:2] opcode;
    logic       data_ref;
    logic       auto_index;

    assign cyc.instruction = instruction;
    assign cyc.ma          = ma;
    assign cyc.isz_skip    = isz_skip;

    assign opcode     = instruction[0:2];
    assign data_ref   = instruction[3] && (opcode inside {AND, TAD, ISZ, DCA});
    assign auto_index = (ma[0:8] == 9'o001);    // 0010 to 0017

    always_comb begin
        addr = ma;
        ema  = if_field;
        case (cyc.state)
            F0, FW, F1, F2, F3: addr = pc;
            E0, EW, E1, E2, E3: begin
                if (data_ref) begin
                    ema = df_field;     // operand of an indirect reference
                end
            end
            default: ;
        endcase
    end

    assign core_addr = {ema, addr};
    assign ram_din   = mdin;
    assign ram_we    = write_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            ma           <= 12'o0000;
            instruction  <= 12'o7000;
            isz_skip     <= 1'b0;
            write_en     <= 1'b0;
            current_page <= '0;
            load_q       <= 1'b0;
            dep_q        <= 1'b0;
        end else begin
            write_en <= 1'b0;
            case (cyc.state)
                IDLE: begin
                    load_q <= addr_load;
                    dep_q  <= dep;
                end
                FW: begin
                    mdout       <= ram_dout;
                    instruction <= ram_dout;
                end
                F2: current_page <= pc[0:4];
                F3: begin
                    case (opcode)
                        IOT, OPR: ma <= pc;
                        default: begin
                            if (instruction[4]) begin
                                ma <= {current_page, instruction[5:11]};
                            end else begin
                                ma <= {5'o00, instruction[5:11]};  // page zero
                            end
                        end
                    endcase
                end
                DW: mdout <= ram_dout;
                D1: begin
                    if (auto_index) begin
                        mdin     <= mdout + 12'o0001;
                        write_en <= 1'b1;
                    end
                end
                D2: begin
                    if (auto_index) begin
                        ma <= mdout + 12'o0001;  // pointer is used after the increment
                    end else begin
                        ma <= mdout;
                    end
                end
                E0: begin
                    if (cyc.int_in_prog) begin
                        instruction <= {JMS, 9'o000};
                        ma          <= INT_VECTOR;
                    end
                end
                EW: mdout <= ram_dout;
                E1: begin
                    case (opcode)
                        ISZ: begin
                            mdin     <= mdout + 12'o0001;
                            write_en <= 1'b1;
                            if (mdout == 12'o7777) begin
                                isz_skip <= 1'b1;
                            end
                        end
                        JMS: begin
                            mdin     <= pc;     // return address
                            write_en <= 1'b1;
                        end
                        DCA: begin
                            mdin     <= ac;
                            write_en <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                E3: isz_skip <= 1'b0;
                HW: mdout <= ram_dout;
                H1: begin
                    if (load_q) begin
                        ma <= sr;
                    end else if (dep_q) begin
                        mdin     <= sr;
                        write_en <= 1'b1;
                    end
                end
                H2: begin
                    if (!load_q) begin
                        ma <= ma + 12'o0001;  // deposit or examine steps on
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* logic/core_ram.sv */
`timescale 1ns/1ps

module core_ram (
    input  logic                 clk,
    input  pdp8_pkg::core_addr_t addr,
    input  pdp8_pkg::word_t      din,
    input  logic                 write_en,
    output pdp8_pkg::word_t      dout
);
    import pdp8_pkg::*;

    word_t mem [0:MEM_WORDS-1];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];  // old data on a same-address write
    end

endmodule

/* logic/major_cycle_if.sv */
`timescale 1ns/1ps

interface major_cycle_if;
    import pdp8_pkg::*;

    major_state_t state;        // current phase
    logic         int_in_prog;  // interrupt entry cycle
    word_t        instruction;
    word_t        ma;
    logic         isz_skip;

    modport seq (
        output state,
        output int_in_prog,
        input  instruction,
        input  ma,
        input  isz_skip
    );

    modport mem (
        input  state,
        input  int_in_prog,
        output instruction,
        output ma,
        output isz_skip
    );

endinterface

/* logic/pdp8_pkg.sv */
package pdp8_pkg;

    // bit 0 is the msb throughout
    typedef logic [0:11] word_t;
    typedef logic [0:2]  field_t;
    typedef logic [0:4]  page_t;
    typedef logic [0:14] core_addr_t;   // field then 12-bit address

    // memory reference and i/o opcodes, instruction[0:2]
    localparam logic [0:2] AND = 3'o0;
    localparam logic [0:2] TAD = 3'o1;
    localparam logic [0:2] ISZ = 3'o2;
    localparam logic [0:2] DCA = 3'o3;
    localparam logic [0:2] JMS = 3'o4;
    localparam logic [0:2] JMP = 3'o5;
    localparam logic [0:2] IOT = 3'o6;
    localparam logic [0:2] OPR = 3'o7;

    localparam word_t HLT_WORD   = 12'o7402;
    localparam word_t INT_VECTOR = 12'o0000;   // pc is saved here on interrupt

    localparam int MEM_WORDS = 32768;

    typedef enum logic [4:0] {
        IDLE,
        F0,
        FW,
        F1,
        F2,
        F3,
        D0,
        DW,
        D1,
        D2,
        D3,
        E0,
        EW,
        E1,
        E2,
        E3,
        H0,
        HW,
        H1,
        H2,
        H3
    } major_state_t;

endpackage
